//--- common/mmcm_reconfig_pkg.sv
package mmcm_reconfig_pkg;

   typedef logic [6:0]  drp_addr_t;
   typedef logic [15:0] drp_data_t;
   typedef logic [5:0]  count_time_t;   // High, low or delay count
   typedef logic [2:0]  phase_mux_t;

   // Issue order of the register steps
   typedef enum logic [2:0] {
      STEP_POWER,
      STEP_CLKOUT0_REG1,
      STEP_CLKOUT0_REG2,
      STEP_DIVCLK,
      STEP_CLKFBOUT_REG1,
      STEP_CLKFBOUT_REG2
   } cfg_step_e;

   typedef enum logic [3:0] {
      RESTART,
      WAIT_LOCK,
      WAIT_START,
      ADDRESS,
      WAIT_A_DRDY,
      BITMASK,
      BITSET,
      WRITE,
      WAIT_DRDY
   } ctrl_state_e;

   // Device register map
   localparam drp_addr_t ADDR_POWER         = 7'h28;
   localparam drp_addr_t ADDR_CLKOUT0_REG1  = 7'h08;
   localparam drp_addr_t ADDR_CLKOUT0_REG2  = 7'h09;
   localparam drp_addr_t ADDR_DIVCLK        = 7'h16;
   localparam drp_addr_t ADDR_CLKFBOUT_REG1 = 7'h14;
   localparam drp_addr_t ADDR_CLKFBOUT_REG2 = 7'h15;

   // Bits kept from the read word
   localparam drp_data_t MASK_POWER  = 16'h0000;
   localparam drp_data_t MASK_REG1   = 16'h1000;
   localparam drp_data_t MASK_REG2   = 16'h8000;
   localparam drp_data_t MASK_DIVCLK = 16'hC000;

   localparam drp_data_t POWER_WORD = 16'hFFFF;

   localparam cfg_step_e LAST_STEP = STEP_CLKFBOUT_REG2;

endpackage

//--- reconfig/reconfig_ctrl.sv
`timescale 1ns/100ps

module reconfig_ctrl (
   input  logic                          dclk,
   input  logic                          rst,
   input  logic                          locked,
   input  logic                          start_reconfig,
   input  logic                          drp_rdy,
   output mmcm_reconfig_pkg::cfg_step_e  step,
   output logic                          issue_read,
   output logic                          apply_mask,
   output logic                          apply_bits,
   output logic                          issue_write,
   output logic                          mmcm_rst,
   output logic                          ready,
   output logic                          reconfig_done
);
   import mmcm_reconfig_pkg::*;

   ctrl_state_e state;
   ctrl_state_e next_state;
   logic        final_write;   // Write in flight belongs to the last step

   always_comb begin
      next_state = state;
      case (state)
         RESTART: begin
            next_state = WAIT_LOCK;
         end
         WAIT_LOCK: begin
            if (locked) begin
               next_state = WAIT_START;
            end
         end
         WAIT_START: begin
            if (start_reconfig) begin
               next_state = ADDRESS;
            end
         end
         ADDRESS: begin
            next_state = WAIT_A_DRDY;
         end
         WAIT_A_DRDY: begin
            if (drp_rdy) begin
               next_state = BITMASK;
            end
         end
         BITMASK: begin
            next_state = BITSET;
         end
         BITSET: begin
            next_state = WRITE;
         end
         WRITE: begin
            next_state = WAIT_DRDY;
         end
         WAIT_DRDY: begin
            if (drp_rdy) begin
               next_state = final_write ? WAIT_LOCK : ADDRESS;
            end
         end
         default: begin
            next_state = RESTART;
         end
      endcase
   end

   // Commands to the DRP datapath reach the bus a cycle later
   assign issue_read  = (state == ADDRESS);
   assign apply_mask  = (state == WAIT_A_DRDY) && drp_rdy;   // drp_do only valid now
   assign apply_bits  = (state == BITMASK);
   assign issue_write = (state == BITSET);

   always_ff @(posedge dclk) begin
      if (rst) begin
         state         <= RESTART;
         step          <= STEP_POWER;
         final_write   <= 1'b0;
         mmcm_rst      <= 1'b1;
         ready         <= 1'b0;
         reconfig_done <= 1'b0;
      end else begin
         state         <= next_state;
         ready         <= (next_state == WAIT_START);
         reconfig_done <= (state == WAIT_DRDY) && drp_rdy && final_write;

         // Manager held in reset from the first read until the last write is done
         if (next_state == WAIT_LOCK) begin
            mmcm_rst <= 1'b0;
         end else if ((next_state == RESTART) || (state == ADDRESS)) begin
            mmcm_rst <= 1'b1;
         end

         if ((state == WAIT_START) && start_reconfig) begin
            step        <= STEP_POWER;
            final_write <= 1'b0;
         end else if (state == BITSET) begin
            final_write <= (step == LAST_STEP);
            if (step != LAST_STEP) begin
               step <= cfg_step_e'(step + 3'd1);
            end
         end
      end
   end

endmodule

//--- reconfig/step_table.sv
`timescale 1ns/100ps

module step_table (
   input  mmcm_reconfig_pkg::cfg_step_e  step,
   output mmcm_reconfig_pkg::drp_addr_t  step_addr,
   output mmcm_reconfig_pkg::drp_data_t  step_mask
);
   import mmcm_reconfig_pkg::*;

   always_comb begin
      case (step)
         STEP_POWER: begin
            step_addr = ADDR_POWER;
            step_mask = MASK_POWER;   // Whole word replaced
         end
         STEP_CLKOUT0_REG1: begin
            step_addr = ADDR_CLKOUT0_REG1;
            step_mask = MASK_REG1;
         end
         STEP_CLKOUT0_REG2: begin
            step_addr = ADDR_CLKOUT0_REG2;
            step_mask = MASK_REG2;    // Fractional bits cleared
         end
         STEP_DIVCLK: begin
            step_addr = ADDR_DIVCLK;
            step_mask = MASK_DIVCLK;
         end
         STEP_CLKFBOUT_REG1: begin
            step_addr = ADDR_CLKFBOUT_REG1;
            step_mask = MASK_REG1;
         end
         STEP_CLKFBOUT_REG2: begin
            step_addr = ADDR_CLKFBOUT_REG2;
            step_mask = MASK_REG2;
         end
         default: begin
            step_addr = ADDR_POWER;
            step_mask = MASK_POWER;
         end
      endcase
   end

endmodule

//--- reconfig/counter_word_pack.sv
`timescale 1ns/100ps

module counter_word_pack (
   input  mmcm_reconfig_pkg::cfg_step_e   step,
   input  mmcm_reconfig_pkg::count_time_t clkout0_high,
   input  mmcm_reconfig_pkg::count_time_t clkout0_low,
   input  mmcm_reconfig_pkg::count_time_t clkout0_delay,
   input  mmcm_reconfig_pkg::phase_mux_t  clkout0_phase,
   input  logic                           clkout0_edge,
   input  logic                           clkout0_no_count,
   input  mmcm_reconfig_pkg::count_time_t fb_high,
   input  mmcm_reconfig_pkg::count_time_t fb_low,
   input  mmcm_reconfig_pkg::count_time_t fb_delay,
   input  mmcm_reconfig_pkg::phase_mux_t  fb_phase,
   input  logic                           fb_edge,
   input  logic                           fb_no_count,
   input  mmcm_reconfig_pkg::count_time_t divclk_high,
   input  mmcm_reconfig_pkg::count_time_t divclk_low,
   input  logic                           divclk_edge,
   input  logic                           divclk_no_count,
   output mmcm_reconfig_pkg::drp_data_t   step_bits
);
   import mmcm_reconfig_pkg::*;

   // Phase tap and high/low counts
   function automatic drp_data_t pack_reg1(phase_mux_t phase, count_time_t high,
                                           count_time_t low);
      return {phase, 1'b0, high, low};
   endfunction

   // Edge, bypass and delay; fractional fields stay zero
   function automatic drp_data_t pack_reg2(logic edge_bit, logic no_count,
                                           count_time_t delay);
      return {8'h00, edge_bit, no_count, delay};
   endfunction

   always_comb begin
      case (step)
         STEP_POWER:         step_bits = POWER_WORD;
         STEP_CLKOUT0_REG1:  step_bits = pack_reg1(clkout0_phase, clkout0_high, clkout0_low);
         STEP_CLKOUT0_REG2:  step_bits = pack_reg2(clkout0_edge, clkout0_no_count,
                                                   clkout0_delay);
         STEP_DIVCLK:        step_bits = {2'b00, divclk_edge, divclk_no_count,
                                          divclk_high, divclk_low};
         STEP_CLKFBOUT_REG1: step_bits = pack_reg1(fb_phase, fb_high, fb_low);
         STEP_CLKFBOUT_REG2: step_bits = pack_reg2(fb_edge, fb_no_count, fb_delay);
         default:            step_bits = '0;
      endcase
   end

endmodule

//--- reconfig/drp_rmw.sv
`timescale 1ns/100ps

module drp_rmw (
   input  logic                          dclk,
   input  logic                          rst,
   input  logic                          issue_read,
   input  logic                          apply_mask,
   input  logic                          apply_bits,
   input  logic                          issue_write,
   input  mmcm_reconfig_pkg::drp_addr_t  step_addr,
   input  mmcm_reconfig_pkg::drp_data_t  step_mask,
   input  mmcm_reconfig_pkg::drp_data_t  step_bits,
   input  mmcm_reconfig_pkg::drp_data_t  drp_do,
   output mmcm_reconfig_pkg::drp_addr_t  drp_addr,
   output mmcm_reconfig_pkg::drp_data_t  drp_di,
   output logic                          drp_en,
   output logic                          drp_we
);

   // One-cycle strobes
   always_ff @(posedge dclk) begin
      if (rst) begin
         drp_en <= 1'b0;
         drp_we <= 1'b0;
      end else begin
         drp_en <= issue_read | issue_write;
         drp_we <= issue_write;
      end
   end

   // Address held from the read through the write
   always_ff @(posedge dclk) begin
      if (issue_read) begin
         drp_addr <= step_addr;
      end
   end

   // Working word built in place on drp_di
   always_ff @(posedge dclk) begin
      if (apply_mask) begin
         drp_di <= drp_do & step_mask;
      end else if (apply_bits) begin
         drp_di <= drp_di | step_bits;
      end
   end

endmodule

//--- src/mmcm_reconfig_top.sv
`timescale 1ns/100ps

module mmcm_reconfig_top (
   input  logic                           dclk,
   input  logic                           rst,
   input  logic                           locked,
   input  logic                           start_reconfig,
   input  logic                           drp_rdy,
   input  mmcm_reconfig_pkg::count_time_t clkout0_high,
   input  mmcm_reconfig_pkg::count_time_t clkout0_low,
   input  mmcm_reconfig_pkg::count_time_t clkout0_delay,
   input  mmcm_reconfig_pkg::phase_mux_t  clkout0_phase,
   input  logic                           clkout0_edge,
   input  logic                           clkout0_no_count,
   input  mmcm_reconfig_pkg::count_time_t fb_high,
   input  mmcm_reconfig_pkg::count_time_t fb_low,
   input  mmcm_reconfig_pkg::count_time_t fb_delay,
   input  mmcm_reconfig_pkg::phase_mux_t  fb_phase,
   input  logic                           fb_edge,
   input  logic                           fb_no_count,
   input  mmcm_reconfig_pkg::count_time_t divclk_high,
   input  mmcm_reconfig_pkg::count_time_t divclk_low,
   input  logic                           divclk_edge,
   input  logic                           divclk_no_count,
   input  mmcm_reconfig_pkg::drp_data_t   drp_do,
   output mmcm_reconfig_pkg::drp_addr_t   drp_addr,
   output mmcm_reconfig_pkg::drp_data_t   drp_di,
   output logic                           drp_en,
   output logic                           drp_we,
   output logic                           mmcm_rst,
   output logic                           ready,
   output logic                           reconfig_done
);
   import mmcm_reconfig_pkg::*;

   cfg_step_e step;
   drp_addr_t step_addr;
   drp_data_t step_mask;
   drp_data_t step_bits;
   logic      issue_read;
   logic      apply_mask;
   logic      apply_bits;
   logic      issue_write;

   reconfig_ctrl u_ctrl (
      .dclk           (dclk),
      .rst            (rst),
      .locked         (locked),
      .start_reconfig (start_reconfig),
      .drp_rdy        (drp_rdy),
      .step           (step),
      .issue_read     (issue_read),
      .apply_mask     (apply_mask),
      .apply_bits     (apply_bits),
      .issue_write    (issue_write),
      .mmcm_rst       (mmcm_rst),
      .ready          (ready),
      .reconfig_done  (reconfig_done)
   );

   step_table u_step_table (
      .step      (step),
      .step_addr (step_addr),
      .step_mask (step_mask)
   );

   counter_word_pack u_pack (
      .step             (step),
      .clkout0_high     (clkout0_high),
      .clkout0_low      (clkout0_low),
      .clkout0_delay    (clkout0_delay),
      .clkout0_phase    (clkout0_phase),
      .clkout0_edge     (clkout0_edge),
      .clkout0_no_count (clkout0_no_count),
      .fb_high          (fb_high),
      .fb_low           (fb_low),
      .fb_delay         (fb_delay),
      .fb_phase         (fb_phase),
      .fb_edge          (fb_edge),
      .fb_no_count      (fb_no_count),
      .divclk_high      (divclk_high),
      .divclk_low       (divclk_low),
      .divclk_edge      (divclk_edge),
      .divclk_no_count  (divclk_no_count),
      .step_bits        (step_bits)
   );

   drp_rmw u_rmw (
      .dclk        (dclk),
      .rst         (rst),
      .issue_read  (issue_read),
      .apply_mask  (apply_mask),
      .apply_bits  (apply_bits),
      .issue_write (issue_write),
      .step_addr   (step_addr),
      .step_mask   (step_mask),
      .step_bits   (step_bits),
      .drp_do      (drp_do),
      .drp_addr    (drp_addr),
      .drp_di      (drp_di),
      .drp_en      (drp_en),
      .drp_we      (drp_we)
   );

endmodule

//--- dv/tb_mmcm_reconfig.sv
`timescale 1ns/100ps

module tb_mmcm_reconfig;
   import mmcm_reconfig_pkg::*;

   localparam int RUNS        = 20;
   localparam int CYCLE_LIMIT = 4000;   // 20 runs of up to 136 cycles, plus reset

   typedef enum {PH_RESET, PH_LOCK, PH_READY, PH_BUSY} tb_phase_e;

   logic        dclk;
   logic        rst;
   logic        locked;
   logic        start_reconfig;
   logic        drp_rdy;
   drp_data_t   drp_do;
   count_time_t clkout0_high, clkout0_low, clkout0_delay;
   phase_mux_t  clkout0_phase;
   logic        clkout0_edge, clkout0_no_count;
   count_time_t fb_high, fb_low, fb_delay;
   phase_mux_t  fb_phase;
   logic        fb_edge, fb_no_count;
   count_time_t divclk_high, divclk_low;
   logic        divclk_edge, divclk_no_count;
   drp_addr_t   drp_addr;
   drp_data_t   drp_di;
   logic        drp_en, drp_we, mmcm_rst, ready, reconfig_done;

   logic [31:0] lfsr;
   drp_data_t   dev_mem [0:127];     // What the device holds
   drp_data_t   model_mem [0:127];   // What it should hold
   drp_addr_t   addr_ref [0:5] = '{7'h28, 7'h08, 7'h09, 7'h16, 7'h14, 7'h15};
   drp_data_t   mask_ref [0:5] = '{16'h0000, 16'h1000, 16'h8000, 16'hC000,
                                   16'h1000, 16'h8000};
   int          errors = 0;
   int          checks = 0;
   int          runs_done = 0;
   int          acc_idx = 0;       // Accesses seen in this run
   int          rdy_wait = 0;
   int          lock_wait = 0;
   int          cycle_count = 0;
   tb_phase_e   phase = PH_RESET;
   logic        in_seq = 1'b0;
   logic        done_due = 1'b0;
   logic        exp_ready = 1'b0;
   logic        mrst_prev = 1'b1;
   logic        lock_level = 1'b0;
   logic        rdy_is_read = 1'b0;
   drp_addr_t   read_addr;
   drp_data_t   read_word;

   mmcm_reconfig_top dut (.*);

   initial dclk = 1'b0;
   always #10 dclk = ~dclk;

   // Polynomial x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic take_bits(input int n, output logic [31:0] val);
      val = '0;
      for (int i = 0; i < n; i++) begin
         val  = {val[30:0], lfsr[0]};
         lfsr = lfsr_next(lfsr);
      end
   endtask

   task automatic compare_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
      end
   endtask

   task automatic report_failure(input string what);
      errors++;
      $display("%0t: %s", $time, what);
   endtask

   task automatic draw_settings;
      logic [31:0] r;
      take_bits(23, r);
      {clkout0_high, clkout0_low, clkout0_delay, clkout0_phase,
       clkout0_edge, clkout0_no_count} = r[22:0];
      take_bits(23, r);
      {fb_high, fb_low, fb_delay, fb_phase, fb_edge, fb_no_count} = r[22:0];
      take_bits(14, r);
      {divclk_high, divclk_low, divclk_edge, divclk_no_count} = r[13:0];
   endtask

   // Field placement per register
   function automatic drp_data_t expected_bits(input int step);
      case (step)
         0: return 16'hFFFF;
         1: return {clkout0_phase, 1'b0, clkout0_high, clkout0_low};
         2: return {8'h00, clkout0_edge, clkout0_no_count, clkout0_delay};
         3: return {2'b00, divclk_edge, divclk_no_count, divclk_high, divclk_low};
         4: return {fb_phase, 1'b0, fb_high, fb_low};
         5: return {8'h00, fb_edge, fb_no_count, fb_delay};
         default: return 16'h0000;
      endcase
   endfunction

   // Device side of the DRP and the lock, plus the checks; values seen here
   // are those of the cycle that ends at this edge
   always @(posedge dclk) begin : device_model
      logic [31:0] r;
      logic        fire_rdy;
      int          step;
      drp_data_t   word;
      fire_rdy = 1'b0;
      step     = acc_idx / 2;
      if (rst) begin
         phase      = PH_RESET;
         mrst_prev  = 1'b1;
         lock_level = 1'b0;
         exp_ready  = 1'b0;
      end else begin
         compare_value("ready", exp_ready, ready);
         if (done_due) begin
            compare_value("reconfig_done", 1, reconfig_done);
            in_seq  = 1'b0;
            acc_idx = 0;
            phase   = PH_LOCK;
            runs_done++;
         end else begin
            compare_value("reconfig_done", 0, reconfig_done);
         end
         if (drp_we && !drp_en) begin
            report_failure("drp_we was high without drp_en");
         end
         if (drp_en) begin
            if (phase != PH_BUSY) begin
               report_failure("DRP access while no reconfiguration was started");
            end else if (rdy_wait != 0) begin
               report_failure("DRP access issued while another was outstanding");
            end else if (acc_idx >= 12) begin
               report_failure("More than twelve DRP accesses in one reconfiguration");
            end else begin
               if (acc_idx == 0) begin
                  in_seq = 1'b1;
               end
               if (acc_idx % 2 == 0) begin
                  compare_value("drp_we", 0, drp_we);
                  compare_value("drp_addr", addr_ref[step], drp_addr);
                  read_addr   = drp_addr;
                  read_word   = dev_mem[drp_addr];
                  rdy_is_read = 1'b1;
               end else begin
                  compare_value("drp_we", 1, drp_we);
                  compare_value("drp_addr", read_addr, drp_addr);
                  word = (model_mem[addr_ref[step]] & mask_ref[step]) | expected_bits(step);
                  model_mem[addr_ref[step]] = word;
                  compare_value("drp_di", word, drp_di);
                  dev_mem[drp_addr] = drp_di;
                  rdy_is_read = 1'b0;
               end
               acc_idx++;
               take_bits(2, r);
               rdy_wait = int'(r[1:0]) + 1;
            end
         end
         // High only from the first read until the last write is answered
         if (phase != PH_RESET) begin
            compare_value("mmcm_rst", in_seq, mmcm_rst);
         end
         done_due = drp_rdy && (acc_idx == 12);   // Last write answered
         if (rdy_wait != 0) begin
            rdy_wait--;
            fire_rdy = (rdy_wait == 0);
         end

         if (mmcm_rst) begin
            lock_level = 1'b0;
            lock_wait  = 0;
         end else if (mrst_prev) begin
            take_bits(3, r);
            lock_wait = int'(r[2:0]) + 2;
         end
         if (lock_wait != 0) begin
            lock_wait--;
            if (lock_wait == 0) begin
               lock_level = 1'b1;
            end
         end
         mrst_prev = mmcm_rst;

         case (phase)
            PH_RESET: phase = PH_LOCK;
            PH_LOCK:  phase = locked ? PH_READY : PH_LOCK;
            PH_READY: phase = start_reconfig ? PH_BUSY : PH_READY;
            default:  phase = phase;
         endcase
         exp_ready = (phase == PH_READY);
      end
      #1;
      drp_rdy = fire_rdy;
      if (fire_rdy && rdy_is_read) begin
         drp_do = read_word;
      end
      locked = lock_level;
   end

   always @(posedge dclk) begin
      cycle_count++;
      if (cycle_count == CYCLE_LIMIT) begin
         $display("Run timed out after %0d cycles with %0d of %0d reconfigurations done",
                  cycle_count, runs_done, RUNS);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   initial begin
      logic [31:0] r;
      lfsr           = 32'h3b93;
      rst            = 1'b1;
      locked         = 1'b0;
      start_reconfig = 1'b0;
      drp_rdy        = 1'b0;
      drp_do         = '0;
      draw_settings();
      for (int a = 0; a < 128; a++) begin
         take_bits(16, r);
         dev_mem[a]   = r[15:0];
         model_mem[a] = r[15:0];
      end
      repeat (3) @(posedge dclk);
      #1 rst = 1'b0;

      // Start during lock wait must be ignored
      @(posedge dclk);
      #1 start_reconfig = 1'b1;
      @(posedge dclk);
      #1 start_reconfig = 1'b0;

      for (int run = 0; run < RUNS; run++) begin
         while (ready !== 1'b1) begin
            @(posedge dclk);
            #1;
         end
         draw_settings();
         start_reconfig = 1'b1;
         @(posedge dclk);
         #1 start_reconfig = 1'b0;
         while (runs_done == run) begin
            @(posedge dclk);
            #1;
         end
         start_reconfig = 1'b1;   // Ignored in lock wait
         for (int a = 0; a < 128; a++) begin
            compare_value("device register", model_mem[a], dev_mem[a]);
         end
         @(posedge dclk);
         #1 start_reconfig = 1'b0;
      end

      $display("Checks: %0d, errors: %0d, reconfigurations: %0d", checks, errors, runs_done);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

//--- flist.f
common/mmcm_reconfig_pkg.sv
reconfig/reconfig_ctrl.sv
reconfig/step_table.sv
reconfig/counter_word_pack.sv
reconfig/drp_rmw.sv
src/mmcm_reconfig_top.sv
dv/tb_mmcm_reconfig.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_mmcm_reconfig -f flist.f
	./obj_dir/Vtb_mmcm_reconfig | tee /dev/stderr | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
